// File: Makefile
VERILATOR = verilator
FLAGS     = --timing --assert
TOP       = tb_spi_fl
FILELIST  = build.f
OBJ_DIR   = obj_dir
LOG       = sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -qF "** PASS **" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: build.f
src/spi_fl_map_pkg.sv
src/spi_fl_proto_pkg.sv
src/spi_fl_regs.sv
src/spi_fl_engine.sv
src/spi_fl_top.sv
tests/spi_fl_asserts.sv
tests/tb_spi_fl.sv

// File: src/spi_fl_engine.sv
`timescale 1ns/1ps
`default_nettype none

module spi_fl_engine #(
    parameter int CLKS_PER_HALF_SCLK = 2
) (
    input  logic                                     clk,
    input  logic                                     reset,
    input  logic                                     soft_reset,
    input  logic                                     start,
    input  logic [spi_fl_proto_pkg::FL_ADDR_W-1:0]   address,
    input  logic [spi_fl_proto_pkg::DATA_W-1:0]      data_in,
    input  logic [7:0]                               command,
    input  logic [5:0]                               ndata_bits,
    input  logic [3:0]                               dummy_cycles,
    input  spi_fl_proto_pkg::comm_type_e             comm_type,
    input  logic                                     miso,
    output logic                                     ready,
    output logic                                     done,
    output logic [spi_fl_proto_pkg::DATA_W-1:0]      data_out,
    output logic                                     sclk,
    output logic                                     ss,
    output logic                                     mosi
);
    import spi_fl_proto_pkg::*;

    localparam int DIV_W = $clog2(CLKS_PER_HALF_SCLK + 1);

    logic              rst_int;
    engine_state_e     state;
    engine_state_e     nxt_state;
    logic [DIV_W-1:0]  div_cnt;
    logic              half_tick;
    logic [5:0]        bit_cnt;
    logic [5:0]        nxt_bits;
    logic [DATA_W-1:0] tx_sr;
    logic [DATA_W-1:0] nxt_sr;
    logic [DATA_W-1:0] data_aligned;
    logic              rx_en;

    // Frame settings captured at start
    comm_type_e        type_r;
    logic [5:0]        nbits_r;
    logic [3:0]        dummy_r;
    logic              has_addr;
    logic              is_rd;
    logic              is_wr;
    logic              to_dummy;

    assign rst_int = reset | soft_reset;

    assign has_addr = (type_r == CT_CMD_ADDR_RD) || (type_r == CT_CMD_ADDR_WR);
    assign is_rd    = (type_r == CT_CMD_RD) || (type_r == CT_CMD_ADDR_RD);
    assign is_wr    = (type_r == CT_CMD_WR) || (type_r == CT_CMD_ADDR_WR);
    assign to_dummy = is_rd && (dummy_r != 4'd0);

    assign half_tick = (div_cnt == DIV_W'(CLKS_PER_HALF_SCLK - 1));

    // Low N bits of data_in moved to the top, counts above 32 lead with zeros
    assign data_aligned = nbits_r[5] ? data_in : (data_in << (6'd32 - nbits_r));

    // Zero padding while the data bit index is 32 or more
    assign mosi = tx_sr[DATA_W-1] & ~bit_cnt[5];

    assign rx_en = half_tick && !sclk && (state == ST_DATA) && is_rd;

    // Phase that follows the last bit of the current one
    always_comb begin
        nxt_state = ST_END;
        nxt_bits  = '0;
        nxt_sr    = '0;
        if (state == ST_CMD && has_addr) begin
            nxt_state = ST_ADDR;
            nxt_bits  = 6'(FL_ADDR_W - 1);
            nxt_sr    = {address, {(DATA_W-FL_ADDR_W){1'b0}}};
        end else if ((state == ST_CMD || state == ST_ADDR) && to_dummy) begin
            nxt_state = ST_DUMMY;
            nxt_bits  = {2'b00, dummy_r} - 6'd1;
        end else if (state != ST_DATA && (is_rd || is_wr)) begin
            nxt_state = ST_DATA;
            nxt_bits  = nbits_r - 6'd1;
            nxt_sr    = is_wr ? data_aligned : '0;
        end
    end

    always_ff @(posedge clk) begin
        if (rst_int) begin
            state   <= ST_IDLE;
            ready   <= 1'b1;
            done    <= 1'b0;
            ss      <= 1'b1;
            sclk    <= 1'b0;
            div_cnt <= '0;
            bit_cnt <= '0;
            tx_sr   <= '0;
        end else begin
            done <= 1'b0;
            case (state)
                ST_IDLE: begin
                    if (start) begin
                        ready   <= 1'b0;
                        ss      <= 1'b0;
                        div_cnt <= '0;
                        bit_cnt <= 6'd7;
                        tx_sr   <= {command, {(DATA_W-8){1'b0}}};
                        state   <= ST_CMD;
                    end
                end
                ST_END: begin
                    // ss rises half a period after the last falling edge
                    if (ss) begin
                        done  <= 1'b1;
                        ready <= 1'b1;
                        state <= ST_IDLE;
                    end else if (half_tick) begin
                        ss <= 1'b1;
                    end
                    div_cnt <= half_tick ? '0 : div_cnt + 1'b1;
                end
                default: begin
                    div_cnt <= half_tick ? '0 : div_cnt + 1'b1;
                    if (half_tick) begin
                        sclk <= ~sclk;
                        // Falling edge moves to the next bit
                        if (sclk) begin
                            if (bit_cnt == 6'd0) begin
                                state   <= nxt_state;
                                bit_cnt <= nxt_bits;
                                tx_sr   <= nxt_sr;
                            end else begin
                                bit_cnt <= bit_cnt - 6'd1;
                                if (!bit_cnt[5]) begin
                                    tx_sr <= tx_sr << 1;
                                end
                            end
                        end
                    end
                end
            endcase
        end
    end

    // Receive shift register, cleared so short reads come back right-aligned
    always_ff @(posedge clk) begin
        if (state == ST_IDLE && start) begin
            type_r   <= comm_type;
            nbits_r  <= (ndata_bits == 6'd0) ? 6'd32 : ndata_bits;
            dummy_r  <= dummy_cycles;
            data_out <= '0;
        end else if (rx_en) begin
            data_out <= {data_out[DATA_W-2:0], miso};
        end
    end

endmodule

`default_nettype wire

// File: src/spi_fl_map_pkg.sv
`default_nettype none

package spi_fl_map_pkg;

    // Word offsets, decoded from wb_adr[4:2]
    localparam logic [2:0] REG_ADDRESS = 3'd0;
    localparam logic [2:0] REG_DATAIN  = 3'd1;
    localparam logic [2:0] REG_COMMAND = 3'd2;
    localparam logic [2:0] REG_CTRL    = 3'd3;
    localparam logic [2:0] REG_STATUS  = 3'd4;
    localparam logic [2:0] REG_DATAOUT = 3'd5;

    // COMMAND word fields
    localparam int CMD_BYTE_LSB  = 0;
    localparam int CMD_W         = 8;
    localparam int CMD_NBITS_LSB = 8;
    localparam int NBITS_W       = 6;
    localparam int CMD_DUMMY_LSB = 16;
    localparam int DUMMY_W       = 4;

    // CTRL word fields
    localparam int CTRL_TYPE_LSB  = 0;
    localparam int CTYPE_W        = 3;
    localparam int CTRL_START_BIT = 8;
    localparam int CTRL_SRST_BIT  = 9;

    // STATUS bits
    localparam int STAT_BUSY_BIT = 0;
    localparam int STAT_DONE_BIT = 1;

endpackage

`default_nettype wire

// File: src/spi_fl_proto_pkg.sv
`default_nettype none

package spi_fl_proto_pkg;

    localparam int FL_ADDR_W = 24;
    localparam int DATA_W    = 32;

    // Frame layout selected by software
    typedef enum logic [2:0] {
        CT_CMD         = 3'd0,
        CT_CMD_RD      = 3'd1,
        CT_CMD_ADDR_RD = 3'd2,
        CT_CMD_WR      = 3'd3,
        CT_CMD_ADDR_WR = 3'd4
    } comm_type_e;

    typedef enum logic [2:0] {
        ST_IDLE  = 3'd0,
        ST_CMD   = 3'd1,
        ST_ADDR  = 3'd2,
        ST_DUMMY = 3'd3,
        ST_DATA  = 3'd4,
        ST_END   = 3'd5
    } engine_state_e;

endpackage

`default_nettype wire

// File: src/spi_fl_regs.sv
`timescale 1ns/1ps
`default_nettype none

module spi_fl_regs (
    input  logic                                     clk,
    input  logic                                     reset,
    input  logic                                     wb_cyc,
    input  logic                                     wb_stb,
    input  logic                                     wb_we,
    input  logic [31:0]                              wb_adr,
    input  logic [spi_fl_proto_pkg::DATA_W-1:0]      wb_dat_w,
    output logic [spi_fl_proto_pkg::DATA_W-1:0]      wb_dat_r,
    output logic                                     wb_ack,
    input  logic                                     ready,
    input  logic                                     done,
    input  logic [spi_fl_proto_pkg::DATA_W-1:0]      data_out,
    output logic                                     start,
    output logic                                     soft_reset,
    output logic [spi_fl_proto_pkg::FL_ADDR_W-1:0]   address,
    output logic [spi_fl_proto_pkg::DATA_W-1:0]      data_in,
    output logic [spi_fl_map_pkg::CMD_W-1:0]         command,
    output logic [spi_fl_map_pkg::NBITS_W-1:0]       ndata_bits,
    output logic [spi_fl_map_pkg::DUMMY_W-1:0]       dummy_cycles,
    output spi_fl_proto_pkg::comm_type_e             comm_type
);
    import spi_fl_map_pkg::*;
    import spi_fl_proto_pkg::*;

    logic [2:0]        word_sel;
    logic              req;
    logic              wr_en;
    logic              ctrl_wr;
    logic              done_flag;
    logic [DATA_W-1:0] dataout_r;
    logic [DATA_W-1:0] rd_mux;

    assign word_sel = wb_adr[4:2];
    assign req      = wb_cyc & wb_stb & ~wb_ack;
    assign wr_en    = req & wb_we;
    assign ctrl_wr  = wr_en && (word_sel == REG_CTRL);

    // Single-cycle ack, one clock after the request is seen
    always_ff @(posedge clk) begin
        if (reset) begin
            wb_ack <= 1'b0;
        end else begin
            wb_ack <= req;
        end
    end

    // Configuration registers
    always_ff @(posedge clk) begin
        if (reset) begin
            address      <= '0;
            data_in      <= '0;
            command      <= '0;
            ndata_bits   <= '0;
            dummy_cycles <= '0;
            comm_type    <= CT_CMD;
        end else if (wr_en) begin
            case (word_sel)
                REG_ADDRESS: address <= wb_dat_w[FL_ADDR_W-1:0];
                REG_DATAIN:  data_in <= wb_dat_w;
                REG_COMMAND: begin
                    command      <= wb_dat_w[CMD_BYTE_LSB +: CMD_W];
                    ndata_bits   <= wb_dat_w[CMD_NBITS_LSB +: NBITS_W];
                    dummy_cycles <= wb_dat_w[CMD_DUMMY_LSB +: DUMMY_W];
                end
                REG_CTRL:    comm_type <= comm_type_e'(wb_dat_w[CTRL_TYPE_LSB +: CTYPE_W]);
                default: ;
            endcase
        end
    end

    // Start only accepted while the engine is idle
    always_ff @(posedge clk) begin
        if (reset) begin
            start      <= 1'b0;
            soft_reset <= 1'b0;
        end else begin
            start      <= ctrl_wr && wb_dat_w[CTRL_START_BIT] && ready;
            soft_reset <= ctrl_wr && wb_dat_w[CTRL_SRST_BIT];
        end
    end

    // Sticky done and captured read data
    always_ff @(posedge clk) begin
        if (reset) begin
            done_flag <= 1'b0;
            dataout_r <= '0;
        end else if (done) begin
            done_flag <= 1'b1;
            dataout_r <= data_out;
        end else if (start) begin
            done_flag <= 1'b0;
        end
    end

    always_comb begin
        rd_mux = '0;
        case (word_sel)
            REG_ADDRESS: rd_mux[FL_ADDR_W-1:0] = address;
            REG_DATAIN:  rd_mux = data_in;
            REG_COMMAND: begin
                rd_mux[CMD_BYTE_LSB +: CMD_W]     = command;
                rd_mux[CMD_NBITS_LSB +: NBITS_W]  = ndata_bits;
                rd_mux[CMD_DUMMY_LSB +: DUMMY_W]  = dummy_cycles;
            end
            REG_CTRL:    rd_mux[CTRL_TYPE_LSB +: CTYPE_W] = comm_type;
            REG_STATUS: begin
                rd_mux[STAT_BUSY_BIT] = ~ready;
                rd_mux[STAT_DONE_BIT] = done_flag;
            end
            REG_DATAOUT: rd_mux = dataout_r;
            default:     rd_mux = '0;
        endcase
    end

    // Read data held for the ack cycle
    always_ff @(posedge clk) begin
        if (req && !wb_we) begin
            wb_dat_r <= rd_mux;
        end
    end

endmodule

`default_nettype wire

// File: src/spi_fl_top.sv
`timescale 1ns/1ps
`default_nettype none

module spi_fl_top #(
    parameter int CLKS_PER_HALF_SCLK = 2
) (
    input  logic                                  clk,
    input  logic                                  reset,
    input  logic                                  wb_cyc,
    input  logic                                  wb_stb,
    input  logic                                  wb_we,
    input  logic [31:0]                           wb_adr,
    input  logic [spi_fl_proto_pkg::DATA_W-1:0]   wb_dat_w,
    output logic [spi_fl_proto_pkg::DATA_W-1:0]   wb_dat_r,
    output logic                                  wb_ack,
    output logic                                  sclk,
    output logic                                  ss,
    output logic                                  mosi,
    input  logic                                  miso
);
    import spi_fl_proto_pkg::*;

    logic                 start;
    logic                 soft_reset;
    logic                 ready;
    logic                 done;
    logic [DATA_W-1:0]    data_out;
    logic [FL_ADDR_W-1:0] address;
    logic [DATA_W-1:0]    data_in;
    logic [7:0]           command;
    logic [5:0]           ndata_bits;
    logic [3:0]           dummy_cycles;
    comm_type_e           comm_type;

    // Software register block
    spi_fl_regs regs0 (
        .clk          (clk),
        .reset        (reset),
        .wb_cyc       (wb_cyc),
        .wb_stb       (wb_stb),
        .wb_we        (wb_we),
        .wb_adr       (wb_adr),
        .wb_dat_w     (wb_dat_w),
        .wb_dat_r     (wb_dat_r),
        .wb_ack       (wb_ack),
        .ready        (ready),
        .done         (done),
        .data_out     (data_out),
        .start        (start),
        .soft_reset   (soft_reset),
        .address      (address),
        .data_in      (data_in),
        .command      (command),
        .ndata_bits   (ndata_bits),
        .dummy_cycles (dummy_cycles),
        .comm_type    (comm_type)
    );

    // Frame engine on the flash pins
    spi_fl_engine #(
        .CLKS_PER_HALF_SCLK (CLKS_PER_HALF_SCLK)
    ) fl_spi0 (
        .clk          (clk),
        .reset        (reset),
        .soft_reset   (soft_reset),
        .start        (start),
        .address      (address),
        .data_in      (data_in),
        .command      (command),
        .ndata_bits   (ndata_bits),
        .dummy_cycles (dummy_cycles),
        .comm_type    (comm_type),
        .miso         (miso),
        .ready        (ready),
        .done         (done),
        .data_out     (data_out),
        .sclk         (sclk),
        .ss           (ss),
        .mosi         (mosi)
    );

endmodule

`default_nettype wire

// File: tests/spi_fl_asserts.sv
`timescale 1ns/1ps
`default_nettype none

module spi_fl_asserts (
    input logic clk,
    input logic reset,
    input logic wb_cyc,
    input logic wb_stb,
    input logic wb_ack,
    input logic sclk,
    input logic ss,
    input logic ready,
    input logic done
);

    // Ack is a single pulse answering a request
    ack_single: assert property (@(posedge clk) disable iff (reset)
        wb_ack |-> ($past(wb_cyc && wb_stb) && !$past(wb_ack)))
        else $error("wb_ack without a request or longer than one cycle");

    sclk_idle: assert property (@(posedge clk) disable iff (reset) ss |-> !sclk)
        else $error("sclk toggled while ss was high");

    // ss low only inside a frame, and its rise ends the frame
    ss_in_frame: assert property (@(posedge clk) disable iff (reset) !ss |-> !ready)
        else $error("ss low while the engine reports ready");

    ss_frame_end: assert property (@(posedge clk) disable iff (reset) $rose(ss) |=> ready)
        else $error("ss rose without the frame ending");

    done_outside: assert property (@(posedge clk) disable iff (reset) done |-> ss)
        else $error("done pulsed while ss was low");

endmodule

`default_nettype wire

// File: tests/tb_spi_fl.sv
`timescale 1ns/1ps
`default_nettype none

module tb_spi_fl;
    import spi_fl_map_pkg::*;
    import spi_fl_proto_pkg::*;

    localparam int HALF_SCLK     = 2;
    localparam int NUM_FRAMES    = 40;
    // Longest frame with a 63 bit data phase, in clocks
    localparam int LONGEST_FRAME = (8 + 24 + 15 + 63) * 2 * HALF_SCLK;
    localparam int BUS_PER_FRAME = 10 * 3;
    localparam int REG_TEST      = 110 * 3;
    localparam int TIMEOUT       = 2 * (NUM_FRAMES * (LONGEST_FRAME + BUS_PER_FRAME)
                                        + REG_TEST + 8);

    logic        clk;
    logic        reset;
    logic        wb_cyc;
    logic        wb_stb;
    logic        wb_we;
    logic [31:0] wb_adr;
    logic [31:0] wb_dat_w;
    logic [31:0] wb_dat_r;
    logic        wb_ack;
    logic        sclk;
    logic        ss;
    logic        mosi;
    logic        miso = 1'b0;

    integer      seed;
    int          err_cnt = 0;
    int          check_cnt = 0;
    int          cycle_cnt = 0;
    logic [31:0] miso_word = 32'h0;
    logic        sclk_q = 1'b0;
    logic        got_bits[$];
    logic        exp_bits[$];

    spi_fl_top #(
        .CLKS_PER_HALF_SCLK (HALF_SCLK)
    ) dut0 (
        .clk      (clk),
        .reset    (reset),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_we    (wb_we),
        .wb_adr   (wb_adr),
        .wb_dat_w (wb_dat_w),
        .wb_dat_r (wb_dat_r),
        .wb_ack   (wb_ack),
        .sclk     (sclk),
        .ss       (ss),
        .mosi     (mosi),
        .miso     (miso)
    );

    bind spi_fl_top spi_fl_asserts asserts0 (
        .clk    (clk),
        .reset  (reset),
        .wb_cyc (wb_cyc),
        .wb_stb (wb_stb),
        .wb_ack (wb_ack),
        .sclk   (sclk),
        .ss     (ss),
        .ready  (ready),
        .done   (done)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt > TIMEOUT) begin
            $display("Timeout: the run did not finish within %0d cycles", TIMEOUT);
            $display("** FAIL **");
            $finish;
        end
    end

    // Flash model samples the pins mid-cycle, one bit per rising sclk
    always @(negedge clk) begin
        sclk_q <= sclk;
        if (!ss && sclk && !sclk_q) begin
            got_bits.push_back(mosi);
        end
    end

    // Next miso bit while sclk is low
    always @(posedge clk) begin
        if (!sclk_q) begin
            miso <= miso_word[31 - (got_bits.size() % 32)];
        end
    end

    task automatic check(input string name, input logic [31:0] expected,
                         input logic [31:0] actual);
        check_cnt++;
        if (expected !== actual) begin
            err_cnt++;
            $display("[ERROR] %s: expected 0x%h, got 0x%h", name, expected, actual);
        end
    endtask

    task automatic wb_write(input logic [2:0] word, input logic [31:0] data);
        @(posedge clk);
        wb_cyc   <= 1'b1;
        wb_stb   <= 1'b1;
        wb_we    <= 1'b1;
        wb_adr   <= {27'd0, word, 2'b00};
        wb_dat_w <= data;
        @(negedge clk);
        while (!wb_ack) @(negedge clk);
        @(posedge clk);
        wb_cyc <= 1'b0;
        wb_stb <= 1'b0;
        wb_we  <= 1'b0;
    endtask

    task automatic wb_read(input logic [2:0] word, output logic [31:0] data);
        @(posedge clk);
        wb_cyc <= 1'b1;
        wb_stb <= 1'b1;
        wb_we  <= 1'b0;
        wb_adr <= {27'd0, word, 2'b00};
        @(negedge clk);
        while (!wb_ack) @(negedge clk);
        data = wb_dat_r;
        @(posedge clk);
        wb_cyc <= 1'b0;
        wb_stb <= 1'b0;
    endtask

    function automatic logic [31:0] ctrl_word(input logic [2:0] t, input logic go,
                                              input logic srst);
        logic [31:0] w;
        w = {29'd0, t};
        w[CTRL_START_BIT] = go;
        w[CTRL_SRST_BIT]  = srst;
        return w;
    endfunction

    function automatic int data_bits(input logic [5:0] nb);
        return (nb == 6'd0) ? 32 : int'(nb);
    endfunction

    function automatic logic is_read(input logic [2:0] t);
        return (t == CT_CMD_RD) || (t == CT_CMD_ADDR_RD);
    endfunction

    function automatic logic is_write(input logic [2:0] t);
        return (t == CT_CMD_WR) || (t == CT_CMD_ADDR_WR);
    endfunction

    // Expected mosi stream, MSB first per field, zeros in dummy and read phases
    task automatic build_expected(input logic [2:0] t, input logic [7:0] cmd,
                                  input logic [23:0] addr, input logic [31:0] din,
                                  input logic [5:0] nb, input logic [3:0] dummy);
        exp_bits.delete();
        for (int i = 7; i >= 0; i--) exp_bits.push_back(cmd[i]);
        if (t == CT_CMD_ADDR_RD || t == CT_CMD_ADDR_WR) begin
            for (int i = 23; i >= 0; i--) exp_bits.push_back(addr[i]);
        end
        if (is_read(t)) begin
            for (int i = 0; i < int'(dummy); i++) exp_bits.push_back(1'b0);
        end
        if (is_read(t) || is_write(t)) begin
            for (int i = data_bits(nb) - 1; i >= 0; i--) begin
                exp_bits.push_back((is_write(t) && i < 32) ? din[i % 32] : 1'b0);
            end
        end
    endtask

    // Last bits of the read phase, right-aligned
    function automatic logic [31:0] expected_dataout(input logic [2:0] t, input logic [5:0] nb,
                                                     input logic [31:0] word, input int len);
        logic [31:0] val;
        int          m;
        val = 32'h0;
        m = (data_bits(nb) > 32) ? 32 : data_bits(nb);
        if (is_read(t)) begin
            for (int k = len - m; k < len; k++) val = {val[30:0], word[31 - (k % 32)]};
        end
        return val;
    endfunction

    task automatic wait_done(output logic [31:0] st);
        st = 32'h0;
        while (!st[STAT_DONE_BIT]) wb_read(REG_STATUS, st);
    endtask

    task automatic program_regs(input logic [7:0] cmd, input logic [23:0] addr,
                                input logic [31:0] din, input logic [5:0] nb,
                                input logic [3:0] dummy);
        wb_write(REG_ADDRESS, {8'd0, addr});
        wb_write(REG_DATAIN, din);
        wb_write(REG_COMMAND, {12'd0, dummy, 2'b00, nb, cmd});
    endtask

    task automatic run_frame(input logic [2:0] t, input logic [7:0] cmd,
                             input logic [23:0] addr, input logic [31:0] din,
                             input logic [5:0] nb, input logic [3:0] dummy,
                             input logic retry_start);
        logic [31:0]  st;
        logic [31:0]  rd;
        logic [127:0] exp_vec;
        logic [127:0] got_vec;
        miso_word = $random(seed);
        build_expected(t, cmd, addr, din, nb, dummy);
        program_regs(cmd, addr, din, nb, dummy);
        got_bits.delete();
        wb_write(REG_CTRL, ctrl_word(t, 1'b1, 1'b0));
        if (retry_start) begin
            wb_read(REG_STATUS, st);
            check("status_busy", 32'h1, st);
            wb_write(REG_CTRL, ctrl_word(t, 1'b1, 1'b0));
        end
        wait_done(st);
        check("status_done", 32'h2, st);
        check("bit_count", exp_bits.size(), got_bits.size());
        exp_vec = '0;
        got_vec = '0;
        foreach (exp_bits[i]) exp_vec = {exp_vec[126:0], exp_bits[i]};
        foreach (got_bits[i]) got_vec = {got_vec[126:0], got_bits[i]};
        for (int w = 3; w >= 0; w--) begin
            check("mosi_stream", exp_vec[w*32 +: 32], got_vec[w*32 +: 32]);
        end
        wb_read(REG_DATAOUT, rd);
        check("dataout", expected_dataout(t, nb, miso_word, exp_bits.size()), rd);
    endtask

    task automatic reg_test();
        logic [31:0] r;
        logic [31:0] rd;
        for (int a = 0; a < 8; a++) begin
            wb_read(3'(a), rd);
            check("reset_value", 32'h0, rd);
        end
        repeat (8) begin
            r = $random(seed);
            wb_write(REG_ADDRESS, r);
            wb_read(REG_ADDRESS, rd);
            check("address", r & 32'h00ff_ffff, rd);
            r = $random(seed);
            wb_write(REG_DATAIN, r);
            wb_read(REG_DATAIN, rd);
            check("datain", r, rd);
            r = $random(seed);
            wb_write(REG_COMMAND, r);
            wb_read(REG_COMMAND, rd);
            check("command", r & 32'h000f_3fff, rd);
            // Type bits only, no start or soft reset
            r = $random(seed) & ~32'h300;
            wb_write(REG_CTRL, r);
            wb_read(REG_CTRL, rd);
            check("ctrl", r & 32'h7, rd);
            wb_write(REG_STATUS, $random(seed));
            wb_read(REG_STATUS, rd);
            check("status", 32'h0, rd);
            wb_write(REG_DATAOUT, $random(seed));
            wb_read(REG_DATAOUT, rd);
            check("dataout_ro", 32'h0, rd);
        end
    endtask

    // Soft reset in the middle of a long read frame
    task automatic soft_reset_test();
        logic [31:0] rd;
        logic [23:0] addr;
        logic [31:0] din;
        addr = 24'($random(seed));
        din  = $random(seed);
        program_regs(8'h0b, addr, din, 6'd0, 4'd8);
        got_bits.delete();
        wb_write(REG_CTRL, ctrl_word(CT_CMD_ADDR_RD, 1'b1, 1'b0));
        while (got_bits.size() < 20) @(posedge clk);
        wb_write(REG_CTRL, ctrl_word(CT_CMD_ADDR_RD, 1'b0, 1'b1));
        wb_read(REG_STATUS, rd);
        check("status_srst", 32'h0, rd);
        check("ss_srst", 32'h1, {31'd0, ss});
        wb_read(REG_ADDRESS, rd);
        check("address_srst", {8'd0, addr}, rd);
        wb_read(REG_DATAIN, rd);
        check("datain_srst", din, rd);
        wb_read(REG_COMMAND, rd);
        check("command_srst", 32'h0008_000b, rd);
        wb_read(REG_CTRL, rd);
        check("ctrl_srst", 32'(CT_CMD_ADDR_RD), rd);
    endtask

    initial begin
        logic [31:0] r1;
        logic [31:0] r2;
        logic [31:0] r3;
        seed     = 32'h48c8;
        reset    = 1'b1;
        wb_cyc   = 1'b0;
        wb_stb   = 1'b0;
        wb_we    = 1'b0;
        wb_adr   = 32'h0;
        wb_dat_w = 32'h0;
        repeat (8) @(posedge clk);
        reset <= 1'b0;
        @(posedge clk);

        reg_test();

        // Types cycle through all codes, including the unused ones
        for (int f = 0; f < NUM_FRAMES - 2; f++) begin
            r1 = $random(seed);
            r2 = $random(seed);
            r3 = $random(seed);
            run_frame(3'(f % 8), r1[7:0], r2[23:0], r3, r1[13:8], r1[19:16],
                      (f % 9) == 4);
        end

        soft_reset_test();
        r1 = $random(seed);
        r2 = $random(seed);
        run_frame(CT_CMD_ADDR_WR, 8'h02, r1[23:0], r2, 6'd32, 4'd0, 1'b0);

        $display("Checks run: %0d, errors: %0d", check_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

`default_nettype wire
